// File: rtl/fp_prep_pkg.sv
// Divide and square-root operand preparation definitions
package fp_prep_pkg;

   ////////////////////////////////
   // Operand and field widths
   ////////////////////////////////

   // Widest operand, binary32
   localparam int unsigned op_width = 32;

   // Widest fields across both formats
   localparam int unsigned exp_width  = 8;
   localparam int unsigned mant_width = 23;

   // Per-format field widths
   localparam int unsigned exp_fp32  = 8;
   localparam int unsigned mant_fp32 = 23;
   localparam int unsigned exp_fp16  = 5;
   localparam int unsigned mant_fp16 = 10;

   // One extra bit keeps the subnormal exponent shift signed
   localparam int unsigned exp_norm_width = exp_width + 1;
   // Fraction plus hidden bit
   localparam int unsigned mant_norm_width = mant_width + 1;
   // Enough for a count up to mant_norm_width
   localparam int unsigned lz_width = 5;
   localparam int unsigned rm_width = 3;

   ////////////////////////////////
   // Types
   ////////////////////////////////

   typedef enum logic
   {
      fmt_fp32 = 1'b0,
      fmt_fp16 = 1'b1
   } fmt_e;

   typedef logic [exp_width-1:0]       exp_t;
   typedef logic [exp_norm_width-1:0]  exp_norm_t;
   typedef logic [mant_width-1:0]      mant_t;
   typedef logic [mant_norm_width-1:0] mant_norm_t;
   typedef logic [rm_width-1:0]        rm_t;

endpackage

// File: rtl/fp_operand_if.sv
// Unpacked operand bundle
interface fp_operand_if;

   // Raw sign of the operand
   logic                   sign;
   // Biased exponent, zero-extended to the widest format
   fp_prep_pkg::exp_t      exp;
   // Hidden bit followed by the left-aligned fraction
   fp_prep_pkg::mant_norm_t mant;

   // Class flags
   logic                   is_zero;
   logic                   is_inf;
   logic                   is_nan;
   logic                   is_snan;

   // Unpacker side
   modport producer (output sign, exp, mant, is_zero, is_inf, is_nan, is_snan);

   // Normalizer and control side
   modport consumer (input sign, exp, mant, is_zero, is_inf, is_nan, is_snan);

endinterface

// File: rtl/fp_unpack.sv
// Operand field split and classification
module fp_unpack
(
   input  fp_prep_pkg::fmt_e                  fmt,
   input  logic [fp_prep_pkg::op_width-1:0]   operand,
   fp_operand_if.producer                     op
);

   // Selected fields
   logic               sign_field;
   fp_prep_pkg::exp_t  exp_field;
   fp_prep_pkg::mant_t frac_field;
   logic               exp_ones;

   // Field tests
   logic               exp_zero;
   logic               frac_zero;

   ////////////////////////////////
   // Field select by format
   ////////////////////////////////

   always_comb
   begin
      if (fmt == fp_prep_pkg::fmt_fp16)
      begin
         // Sign sits just above the 5-bit exponent
         sign_field = operand[fp_prep_pkg::exp_fp16 + fp_prep_pkg::mant_fp16];
         exp_field  = {{(fp_prep_pkg::exp_width - fp_prep_pkg::exp_fp16){1'b0}},
                       operand[fp_prep_pkg::exp_fp16 + fp_prep_pkg::mant_fp16 - 1 :
                               fp_prep_pkg::mant_fp16]};
         // Fraction left-aligned so the quiet bit lands on the top bit
         frac_field = {operand[fp_prep_pkg::mant_fp16-1:0],
                       {(fp_prep_pkg::mant_width - fp_prep_pkg::mant_fp16){1'b0}}};
         exp_ones   = &operand[fp_prep_pkg::exp_fp16 + fp_prep_pkg::mant_fp16 - 1 :
                               fp_prep_pkg::mant_fp16];
      end
      else
      begin
         sign_field = operand[fp_prep_pkg::op_width-1];
         exp_field  = operand[fp_prep_pkg::exp_fp32 + fp_prep_pkg::mant_fp32 - 1 :
                              fp_prep_pkg::mant_fp32];
         frac_field = operand[fp_prep_pkg::mant_fp32-1:0];
         exp_ones   = &operand[fp_prep_pkg::exp_fp32 + fp_prep_pkg::mant_fp32 - 1 :
                               fp_prep_pkg::mant_fp32];
      end
   end

   assign exp_zero  = ~(|exp_field);
   assign frac_zero = ~(|frac_field);

   ////////////////////////////////
   // Bundle outputs
   ////////////////////////////////

   assign op.sign = sign_field;
   assign op.exp  = exp_field;
   // Hidden bit is set for every nonzero exponent
   assign op.mant = {~exp_zero, frac_field};

   // Classification
   assign op.is_zero = exp_zero & frac_zero;
   assign op.is_inf  = exp_ones & frac_zero;
   assign op.is_nan  = exp_ones & ~frac_zero;
   // Signalling when the quiet bit is clear
   assign op.is_snan = exp_ones & ~frac_zero & ~frac_field[fp_prep_pkg::mant_width-1];

endmodule

// File: rtl/fp_normalize.sv
// Subnormal mantissa normalizer
module fp_normalize
(
   input  logic                     Clk_CI,
   input  logic                     Rst_RBI,
   input  logic                     capture,
   fp_operand_if.consumer           op,
   output fp_prep_pkg::mant_norm_t  mant_norm,
   output fp_prep_pkg::exp_norm_t   exp_norm
);

   logic [fp_prep_pkg::lz_width-1:0] lz_cnt;
   logic                             lz_found;
   logic                             lz_any;
   fp_prep_pkg::mant_norm_t          mant_shift;
   fp_prep_pkg::exp_norm_t           exp_adj;

   ////////////////////////////////
   // Leading-zero count
   ////////////////////////////////

   always_comb
   begin
      lz_cnt   = '0;
      lz_found = 1'b0;
      // Scan from the hidden bit down
      for (int i = fp_prep_pkg::mant_norm_width - 1; i >= 0; i--)
      begin
         if (!lz_found)
         begin
            if (op.mant[i])
               lz_found = 1'b1;
            else
               lz_cnt = lz_cnt + 1'b1;
         end
      end
      // All-zero mantissa needs no shift
      if (!lz_found)
         lz_cnt = '0;
   end

   assign lz_any = |lz_cnt;

   // Shift leading one up to the hidden bit position
   assign mant_shift = op.mant << lz_cnt;

   // Subnormals carry an effective exponent of one, hence the extra one
   assign exp_adj = {1'b0, op.exp} - fp_prep_pkg::exp_norm_t'(lz_cnt)
                    + fp_prep_pkg::exp_norm_t'(lz_any);

   // Capture registers
   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (!Rst_RBI)
      begin
         mant_norm <= '0;
         exp_norm  <= '0;
      end
      else if (capture)
      begin
         mant_norm <= mant_shift;
         exp_norm  <= exp_adj;
      end
   end

endmodule

// File: rtl/fp_class_ctrl.sv
// Special-case control and class flag registers
module fp_class_ctrl
(
   input  logic                Clk_CI,
   input  logic                Rst_RBI,
   input  logic                div_start,
   input  logic                sqrt_start,
   input  logic                ready,
   input  fp_prep_pkg::rm_t    rm,
   fp_operand_if.consumer      op_a,
   fp_operand_if.consumer      op_b,
   output logic                capture,
   output logic                start,
   output logic                zero_a,
   output logic                zero_b,
   output logic                inf_a,
   output logic                inf_b,
   output logic                nan_a,
   output logic                nan_b,
   output logic                snan,
   output logic                sign_z,
   output fp_prep_pkg::rm_t    rm_dly,
   output logic                special_case_n,
   output logic                special_case_dly_n
);

   logic div_special;
   logic sqrt_special;
   logic sign_sel;

   ////////////////////////////////
   // Start and capture event
   ////////////////////////////////

   assign start   = div_start | sqrt_start;
   // Only place where the capture condition is formed
   assign capture = start & ready;

   ////////////////////////////////
   // Special-case detection
   ////////////////////////////////

   // Any zero, infinity or NaN on either side
   assign div_special = op_a.is_zero | op_b.is_zero | op_a.is_inf | op_b.is_inf |
                        op_a.is_nan | op_b.is_nan;

   // Square root only looks at operand a, negative inputs included
   assign sqrt_special = op_a.is_zero | op_a.is_inf | op_a.is_nan | op_a.sign;

   // Divide wins when both strobes are high
   assign special_case_n = capture & ~(div_start ? div_special : sqrt_special);

   // Result sign
   assign sign_sel = div_start ? (op_a.sign ^ op_b.sign) : op_a.sign;

   // Flag and mode registers, loaded on capture
   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (!Rst_RBI)
      begin
         zero_a             <= 1'b0;
         zero_b             <= 1'b0;
         inf_a              <= 1'b0;
         inf_b              <= 1'b0;
         nan_a              <= 1'b0;
         nan_b              <= 1'b0;
         snan               <= 1'b0;
         sign_z             <= 1'b0;
         rm_dly             <= '0;
         special_case_dly_n <= 1'b0;
      end
      else if (capture)
      begin
         zero_a             <= op_a.is_zero;
         zero_b             <= op_b.is_zero;
         inf_a              <= op_a.is_inf;
         inf_b              <= op_b.is_inf;
         nan_a              <= op_a.is_nan;
         nan_b              <= op_b.is_nan;
         snan               <= op_a.is_snan | op_b.is_snan;
         sign_z             <= sign_sel;
         rm_dly             <= rm;
         special_case_dly_n <= special_case_n;
      end
   end

endmodule

// File: rtl/div_sqrt_preprocess.sv
// Divide and square-root operand preprocessing
module div_sqrt_preprocess
(
   input  logic                               Clk_CI,
   input  logic                               Rst_RBI,
   input  logic                               div_start,
   input  logic                               sqrt_start,
   input  logic                               ready,
   input  logic [fp_prep_pkg::op_width-1:0]   operand_a,
   input  logic [fp_prep_pkg::op_width-1:0]   operand_b,
   input  fp_prep_pkg::rm_t                   rm,
   input  fp_prep_pkg::fmt_e                  fmt,
   output logic                               start,
   output fp_prep_pkg::mant_norm_t            mant_a_norm,
   output fp_prep_pkg::mant_norm_t            mant_b_norm,
   output fp_prep_pkg::exp_norm_t             exp_a_norm,
   output fp_prep_pkg::exp_norm_t             exp_b_norm,
   output logic                               zero_a,
   output logic                               zero_b,
   output logic                               inf_a,
   output logic                               inf_b,
   output logic                               nan_a,
   output logic                               nan_b,
   output logic                               snan,
   output logic                               sign_z,
   output fp_prep_pkg::rm_t                   rm_dly,
   output logic                               special_case_n,
   output logic                               special_case_dly_n
);

   // Shared load strobe from the control block
   logic capture;

   // One bundle per operand
   fp_operand_if op_a_bus ();
   fp_operand_if op_b_bus ();

   ////////////////////////////////
   // Unpack
   ////////////////////////////////

   fp_unpack i_unpack_a
   (
      .fmt     (fmt),
      .operand (operand_a),
      .op      (op_a_bus.producer)
   );

   fp_unpack i_unpack_b
   (
      .fmt     (fmt),
      .operand (operand_b),
      .op      (op_b_bus.producer)
   );

   ////////////////////////////////
   // Normalize
   ////////////////////////////////

   fp_normalize i_normalize_a
   (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .capture   (capture),
      .op        (op_a_bus.consumer),
      .mant_norm (mant_a_norm),
      .exp_norm  (exp_a_norm)
   );

   fp_normalize i_normalize_b
   (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .capture   (capture),
      .op        (op_b_bus.consumer),
      .mant_norm (mant_b_norm),
      .exp_norm  (exp_b_norm)
   );

   // Class flags, sign, rounding mode and special cases
   fp_class_ctrl i_class_ctrl
   (
      .Clk_CI             (Clk_CI),
      .Rst_RBI            (Rst_RBI),
      .div_start          (div_start),
      .sqrt_start         (sqrt_start),
      .ready              (ready),
      .rm                 (rm),
      .op_a               (op_a_bus.consumer),
      .op_b               (op_b_bus.consumer),
      .capture            (capture),
      .start              (start),
      .zero_a             (zero_a),
      .zero_b             (zero_b),
      .inf_a              (inf_a),
      .inf_b              (inf_b),
      .nan_a              (nan_a),
      .nan_b              (nan_b),
      .snan               (snan),
      .sign_z             (sign_z),
      .rm_dly             (rm_dly),
      .special_case_n     (special_case_n),
      .special_case_dly_n (special_case_dly_n)
   );

endmodule

// File: tb/div_sqrt_preprocess_properties.sv
// Preprocessing stage checker
module div_sqrt_preprocess_properties
(
   input logic                             Clk_CI,
   input logic                             Rst_RBI,
   input logic                             div_start,
   input logic                             sqrt_start,
   input logic                             ready,
   input logic [fp_prep_pkg::op_width-1:0] operand_a,
   input logic [fp_prep_pkg::op_width-1:0] operand_b,
   input fp_prep_pkg::rm_t                 rm,
   input fp_prep_pkg::fmt_e                fmt,
   input logic                             start,
   input fp_prep_pkg::mant_norm_t          mant_a_norm,
   input fp_prep_pkg::mant_norm_t          mant_b_norm,
   input fp_prep_pkg::exp_norm_t           exp_a_norm,
   input fp_prep_pkg::exp_norm_t           exp_b_norm,
   input logic                             zero_a,
   input logic                             zero_b,
   input logic                             inf_a,
   input logic                             inf_b,
   input logic                             nan_a,
   input logic                             nan_b,
   input logic                             snan,
   input logic                             sign_z,
   input fp_prep_pkg::rm_t                 rm_dly,
   input logic                             special_case_n,
   input logic                             special_case_dly_n
);
   timeunit 1ns;
   timeprecision 1ps;

   // Bumped by every failing assertion
   int unsigned err_cnt = 0;

   // Inputs seen at the most recent capture
   logic              seen_cap;
   logic [31:0]       a_q;
   logic [31:0]       b_q;
   logic              f16_q;
   logic              div_q;
   fp_prep_pkg::rm_t  rm_q;

   // Reference values and observed groups
   logic              f16;
   logic              cap_now;
   logic [3:0]        cls_a;
   logic [3:0]        cls_b;
   logic [6:0]        cls_exp;
   logic [6:0]        flags;
   logic              sign_exp;
   logic [32:0]       norm_a_exp;
   logic [32:0]       norm_b_exp;
   // Every registered output in one vector
   logic [77:0]       reg_all;

   ////////////////////////////////
   // Reference model
   ////////////////////////////////

   // Sign, zero-extended exponent and left-aligned fraction
   function automatic logic [31:0] fields_of(input logic [31:0] x, input logic f16_sel);
      if (f16_sel)
         return {x[15], 3'b000, x[14:10], x[9:0], 13'd0};
      return x;
   endfunction

   // Bits are snan, nan, inf, zero from the top
   function automatic logic [3:0] class_of(input logic [31:0] x, input logic f16_sel);
      logic [31:0] s;
      logic        all_ones;
      logic        frac_nz;
      s        = fields_of(x, f16_sel);
      all_ones = f16_sel ? (s[30:23] == 8'd31) : (s[30:23] == 8'd255);
      frac_nz  = s[22:0] != 23'd0;
      return {all_ones && frac_nz && !s[22], all_ones && frac_nz, all_ones && !frac_nz,
              s[30:23] == 8'd0 && !frac_nz};
   endfunction

   // Normalized exponent on top of the mantissa with its leading one
   function automatic logic [32:0] norm_of(input logic [31:0] x, input logic f16_sel);
      logic [31:0] s;
      logic [23:0] m;
      logic [8:0]  e;
      s = fields_of(x, f16_sel);
      m = {s[30:23] != 8'd0, s[22:0]};
      e = {1'b0, s[30:23]};
      if (s[30:23] == 8'd0 && m != 24'd0)
      begin
         // Subnormals start from an effective exponent of one
         e = 9'd1;
         for (int k = 0; k < 24; k++)
         begin
            if (!m[23])
            begin
               m = m << 1;
               e = e - 9'd1;
            end
         end
      end
      return {e, m};
   endfunction

   // High when the operation needs no special handling
   function automatic logic no_special(input logic [31:0] a, input logic [31:0] b,
                                       input logic f16_sel, input logic div);
      logic [3:0]  ca;
      logic [3:0]  cb;
      logic [31:0] sa;
      ca = class_of(a, f16_sel);
      cb = class_of(b, f16_sel);
      sa = fields_of(a, f16_sel);
      if (div)
         return ca[2:0] == 3'd0 && cb[2:0] == 3'd0;
      return ca[2:0] == 3'd0 && !sa[31];
   endfunction

   assign f16     = fmt == fp_prep_pkg::fmt_fp16;
   assign cap_now = (div_start | sqrt_start) & ready;

   // Copy of the captured inputs
   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (!Rst_RBI)
      begin
         seen_cap <= 1'b0;
         a_q      <= '0;
         b_q      <= '0;
         f16_q    <= 1'b0;
         div_q    <= 1'b0;
         rm_q     <= '0;
      end
      else if (cap_now)
      begin
         seen_cap <= 1'b1;
         a_q      <= operand_a;
         b_q      <= operand_b;
         f16_q    <= f16;
         div_q    <= div_start;
         rm_q     <= rm;
      end
   end

   assign cls_a      = class_of(a_q, f16_q);
   assign cls_b      = class_of(b_q, f16_q);
   assign cls_exp    = {cls_a[2:0], cls_b[2:0], cls_a[3] | cls_b[3]};
   assign flags      = {nan_a, inf_a, zero_a, nan_b, inf_b, zero_b, snan};
   // Divide takes priority over square root
   assign sign_exp   = div_q ? (a_q[f16_q ? 15 : 31] ^ b_q[f16_q ? 15 : 31])
                             : a_q[f16_q ? 15 : 31];
   assign norm_a_exp = norm_of(a_q, f16_q);
   assign norm_b_exp = norm_of(b_q, f16_q);
   assign reg_all    = {flags, sign_z, rm_dly, special_case_dly_n, exp_a_norm, mant_a_norm,
                        exp_b_norm, mant_b_norm};

   ////////////////////////////////
   // Properties
   ////////////////////////////////

   // Every register stays at reset until the first capture
   p_reset : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      !seen_cap |-> reg_all == '0)
   else
   begin
      err_cnt++;
      $error("[FAIL] p_reset expected 0 actual %h", $sampled(reg_all));
   end

   p_class : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      seen_cap |-> flags == cls_exp)
   else
   begin
      err_cnt++;
      $error("[FAIL] p_class expected %b actual %b", $sampled(cls_exp), $sampled(flags));
   end

   // Sign and rounding mode also cover the hold with ready low
   p_sign_rm : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      seen_cap |-> {sign_z, rm_dly} == {sign_exp, rm_q})
   else
   begin
      err_cnt++;
      $error("[FAIL] p_sign_rm expected %b actual %b", $sampled({sign_exp, rm_q}),
             $sampled({sign_z, rm_dly}));
   end

   p_norm_a : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      seen_cap |-> {exp_a_norm, mant_a_norm} == norm_a_exp)
   else
   begin
      err_cnt++;
      $error("[FAIL] p_norm_a expected %h actual %h", $sampled(norm_a_exp),
             $sampled({exp_a_norm, mant_a_norm}));
   end

   p_norm_b : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      seen_cap |-> {exp_b_norm, mant_b_norm} == norm_b_exp)
   else
   begin
      err_cnt++;
      $error("[FAIL] p_norm_b expected %h actual %h", $sampled(norm_b_exp),
             $sampled({exp_b_norm, mant_b_norm}));
   end

   // Low outside a capture cycle
   p_special : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      special_case_n == (cap_now && no_special(operand_a, operand_b, f16, div_start)))
   else
   begin
      err_cnt++;
      $error("[FAIL] p_special expected %b actual %b",
             $sampled(cap_now && no_special(operand_a, operand_b, f16, div_start)),
             $sampled(special_case_n));
   end

   p_special_dly : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      seen_cap |-> special_case_dly_n == no_special(a_q, b_q, f16_q, div_q))
   else
   begin
      err_cnt++;
      $error("[FAIL] p_special_dly expected %b actual %b",
             $sampled(no_special(a_q, b_q, f16_q, div_q)), $sampled(special_case_dly_n));
   end

   p_start : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
      start == (div_start | sqrt_start))
   else
   begin
      err_cnt++;
      $error("[FAIL] p_start expected %b actual %b", $sampled(div_start | sqrt_start),
             $sampled(start));
   end

endmodule

// File: tb/tb_div_sqrt_preprocess.sv
// Preprocessing stage testbench
module tb_div_sqrt_preprocess;
   timeunit 1ns;
   timeprecision 1ps;

   // Cycles allowed for start to follow the strobes
   localparam int unsigned wait_limit = 8;

   logic                             Clk_CI;
   logic                             Rst_RBI;
   logic                             div_start;
   logic                             sqrt_start;
   logic                             ready;
   logic [fp_prep_pkg::op_width-1:0] operand_a;
   logic [fp_prep_pkg::op_width-1:0] operand_b;
   fp_prep_pkg::rm_t                 rm;
   fp_prep_pkg::fmt_e                fmt;
   logic                             start;
   fp_prep_pkg::mant_norm_t          mant_a_norm;
   fp_prep_pkg::mant_norm_t          mant_b_norm;
   fp_prep_pkg::exp_norm_t           exp_a_norm;
   fp_prep_pkg::exp_norm_t           exp_b_norm;
   logic                             zero_a;
   logic                             zero_b;
   logic                             inf_a;
   logic                             inf_b;
   logic                             nan_a;
   logic                             nan_b;
   logic                             snan;
   logic                             sign_z;
   fp_prep_pkg::rm_t                 rm_dly;
   logic                             special_case_n;
   logic                             special_case_dly_n;

   logic [31:0] lfsr_state = 32'h8b12_f73a;

   // Zeros, infinities, quiet and signalling NaNs, normals, subnormals, negatives
   logic [31:0] dir32 [11] = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000,
                               32'hff80_0000, 32'h7fc0_0000, 32'h7f80_0001,
                               32'h3f80_0000, 32'h4049_0fdb, 32'h0000_0001,
                               32'h0040_0000, 32'hc000_0000};
   logic [15:0] dir16 [9]  = '{16'h0000, 16'h8000, 16'h7c00, 16'h7e00, 16'h7c01,
                               16'h3c00, 16'h0001, 16'h0200, 16'hbc00};

   div_sqrt_preprocess i_div_sqrt_preprocess (.*);

   bind div_sqrt_preprocess div_sqrt_preprocess_properties i_properties (.*);

   initial
   begin
      Clk_CI = 1'b0;
      forever #4 Clk_CI = ~Clk_CI;
   end

   task automatic fail_run(input string why);
      $display("TESTS FAILED");
      $fatal(1, why);
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic next_lfsr_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++)
         r = {r[30:0], next_lfsr_bit()};
      return r;
   endfunction

   // Drives one request just after an edge and returns on the edge that sees start
   task automatic issue(input logic d, input logic s, input logic r, input logic [31:0] a,
                        input logic [31:0] b, input logic f16, input fp_prep_pkg::rm_t m);
      logic seen;
      #1;
      div_start  = d;
      sqrt_start = s;
      ready      = r;
      operand_a  = a;
      operand_b  = b;
      fmt        = fp_prep_pkg::fmt_e'(f16);
      rm         = m;
      seen       = 1'b0;
      for (int n = 0; n < wait_limit && !seen; n++)
      begin
         @(posedge Clk_CI);
         seen = start;
      end
      if (!seen)
         fail_run("The start output never followed the start strobes");
   endtask

   task automatic idle(input int cycles);
      #1;
      div_start  = 1'b0;
      sqrt_start = 1'b0;
      repeat (cycles) @(posedge Clk_CI);
   endtask

   // First counted property failure ends the run
   always @(i_div_sqrt_preprocess.i_properties.err_cnt)
      if (i_div_sqrt_preprocess.i_properties.err_cnt != 0)
         fail_run("A property of the preprocessing stage failed");

   initial
   begin
      #100_000;
      fail_run("The simulation ran past its time limit");
   end

   ////////////////////////////////
   // Stimulus
   ////////////////////////////////

   initial
   begin
      logic [1:0]  sel;
      logic [31:0] a;
      logic [31:0] b;
      Rst_RBI    = 1'b0;
      div_start  = 1'b0;
      sqrt_start = 1'b0;
      ready      = 1'b1;
      operand_a  = '0;
      operand_b  = '0;
      rm         = '0;
      fmt        = fp_prep_pkg::fmt_fp32;
      repeat (2) @(posedge Clk_CI);
      #1;
      Rst_RBI = 1'b1;
      // A few cycles with no capture after reset
      repeat (2) @(posedge Clk_CI);

      // Directed binary32 as divide then square root then a stalled divide
      for (int i = 0; i < 11; i++)
      begin
         issue(1'b1, 1'b0, 1'b1, dir32[i], dir32[(i + 4) % 11], 1'b0, 3'(i));
         issue(1'b0, 1'b1, 1'b1, dir32[i], dir32[(i + 7) % 11], 1'b0, 3'(i + 1));
         issue(1'b1, 1'b0, 1'b0, dir32[(i + 2) % 11], dir32[i], 1'b0, 3'(i + 2));
      end

      // Directed binary16 with junk in the unused upper half
      for (int i = 0; i < 9; i++)
      begin
         a = {16'(rand_bits(16)), dir16[i]};
         b = {16'(rand_bits(16)), dir16[(i + 3) % 9]};
         issue(1'b1, 1'b0, 1'b1, a, b, 1'b1, 3'(i));
         issue(1'b0, 1'b1, 1'b1, b, a, 1'b1, 3'(i + 5));
         issue(1'b1, 1'b1, 1'b1, a, b, 1'b1, 3'(i + 3));
      end

      // Random operands, formats, modes and stalls
      for (int i = 0; i < 64; i++)
      begin
         sel = 2'(rand_bits(2));
         a   = rand_bits(32);
         b   = rand_bits(32);
         issue(sel != 2'd1, sel == 2'd1 || sel == 2'd2, sel != 2'd3, a, b,
               rand_bits(1) != 0, fp_prep_pkg::rm_t'(rand_bits(3)));
         if (i % 8 == 7)
            idle(2);
      end
      idle(3);

      if (i_div_sqrt_preprocess.i_properties.err_cnt == 0)
      begin
         $display("TESTS PASSED");
         $finish;
      end
      else
         fail_run("Property failures were counted by the end of the run");
   end

endmodule

// File: vlog.f
rtl/fp_prep_pkg.sv
rtl/fp_operand_if.sv
rtl/fp_unpack.sv
rtl/fp_normalize.sv
rtl/fp_class_ctrl.sv
rtl/div_sqrt_preprocess.sv
tb/div_sqrt_preprocess_properties.sv
tb/tb_div_sqrt_preprocess.sv

// File: Bender.yml
package:
  name: div_sqrt_preprocess

sources:
  - files:
      - rtl/fp_prep_pkg.sv
      - rtl/fp_operand_if.sv
      - rtl/fp_unpack.sv
      - rtl/fp_normalize.sv
      - rtl/fp_class_ctrl.sv
      - rtl/div_sqrt_preprocess.sv
  - target: test
    files:
      - tb/div_sqrt_preprocess_properties.sv
      - tb/tb_div_sqrt_preprocess.sv
